// File: include/lc4_cfg.svh
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// data and instruction width
`define LC4_WORD_W 16

// register file geometry
`define LC4_REG_COUNT 8
`define LC4_REG_SEL_W 3

// first fetch address after reset
`define LC4_PC_RESET 16'h8200

// BR with an empty mask, never taken
`define LC4_NOP 16'h0000

`endif

// File: rtl/lc4_alu.sv
`timescale 1ns/1ps

module lc4_alu import lc4_isa_pkg::*; (
   input  alu_op_e i_op,
   input  word_t   i_pc,
   input  word_t   i_insn,
   input  word_t   i_a,
   input  word_t   i_b,
   output word_t   o_result
);

   word_t imm5;
   word_t imm6;
   word_t imm9;

   assign imm5 = word_t'($signed(i_insn[4:0]));
   assign imm6 = word_t'($signed(i_insn[5:0]));
   assign imm9 = word_t'($signed(i_insn[8:0]));

   always_comb begin
      case (i_op)
         ALU_ADD:     o_result = i_a + i_b;
         ALU_SUB:     o_result = i_a - i_b;
         ALU_AND:     o_result = i_a & i_b;
         ALU_NOT:     o_result = ~i_a;
         ALU_OR:      o_result = i_a | i_b;
         ALU_XOR:     o_result = i_a ^ i_b;
         ALU_ADD_IMM: o_result = i_a + imm5;
         ALU_AND_IMM: o_result = i_a & imm5;
         ALU_CONST:   o_result = imm9;
         ALU_ADDR:    o_result = i_a + imm6;
         // branch target rides on the result
         default:     o_result = i_pc + word_t'(1) + imm9;
      endcase
   end

endmodule

// File: rtl/lc4_core.sv
`timescale 1ns/1ps

module lc4_core import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic     gwe,
   input  logic     i_reset,
   output word_t    o_imem_addr,
   input  word_t    i_imem_insn,
   output word_t    o_dmem_addr,
   output word_t    o_dmem_wdata,
   output logic     o_dmem_we,
   input  word_t    i_dmem_rdata,
   output stall_e   o_test_stall,
   output word_t    o_test_pc,
   output word_t    o_test_insn,
   output logic     o_test_rf_we,
   output reg_sel_t o_test_rf_wsel,
   output word_t    o_test_rf_data,
   output logic     o_test_dmem_we,
   output word_t    o_test_dmem_addr,
   output word_t    o_test_dmem_data
);

   // F/D slot
   word_t    d_pc, d_insn;
   stall_e   d_stall;

   // decoded fields and register reads
   reg_sel_t d_rs, d_rt, d_rd;
   logic     d_rs_re, d_rt_re, d_rf_we, d_sets_nzp;
   logic     d_is_load, d_is_store, d_is_branch;
   alu_op_e  d_alu_op;
   word_t    d_rs_data, d_rt_data;
   logic     load_use;

   // redirect and hazard info from X
   logic     flush;
   word_t    branch_target;
   reg_sel_t x_rd;
   logic     x_rf_we, x_is_load;

   // X/M slot
   word_t    m_pc, m_insn, m_result, m_rt_data;
   stall_e   m_stall;
   reg_sel_t m_rd, m_rt;
   logic     m_rf_we, m_sets_nzp, m_is_load, m_is_store;

   // writeback
   reg_sel_t w_rd;
   logic     w_rf_we, w_sets_nzp;
   word_t    w_data;
   nzp_t     nzp;

   lc4_fetch fetch0 (
      .gwe(gwe), .i_reset(i_reset),
      .i_load_use(load_use), .i_flush(flush), .i_branch_target(branch_target),
      .i_imem_insn(i_imem_insn), .o_imem_addr(o_imem_addr),
      .o_d_pc(d_pc), .o_d_insn(d_insn), .o_d_stall(d_stall)
   );

   lc4_decode decode0 (
      .i_insn(d_insn), .i_stall(d_stall),
      .i_x_rd(x_rd), .i_x_rf_we(x_rf_we), .i_x_is_load(x_is_load),
      .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
      .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_rf_we(d_rf_we), .o_sets_nzp(d_sets_nzp),
      .o_is_load(d_is_load), .o_is_store(d_is_store), .o_is_branch(d_is_branch),
      .o_alu_op(d_alu_op), .o_load_use(load_use)
   );

   lc4_regfile regfile0 (
      .gwe(gwe), .i_reset(i_reset),
      .i_rs(d_rs), .i_rt(d_rt), .o_rs_data(d_rs_data), .o_rt_data(d_rt_data),
      .i_rd(w_rd), .i_wdata(w_data), .i_we(w_rf_we)
   );

   lc4_execute execute0 (
      .gwe(gwe), .i_reset(i_reset),
      .i_d_pc(d_pc), .i_d_insn(d_insn), .i_d_stall(d_stall),
      .i_d_rs(d_rs), .i_d_rt(d_rt), .i_d_rd(d_rd),
      .i_d_rs_re(d_rs_re), .i_d_rt_re(d_rt_re),
      .i_d_rf_we(d_rf_we), .i_d_sets_nzp(d_sets_nzp),
      .i_d_is_load(d_is_load), .i_d_is_store(d_is_store), .i_d_is_branch(d_is_branch),
      .i_d_alu_op(d_alu_op), .i_d_rs_data(d_rs_data), .i_d_rt_data(d_rt_data),
      .i_load_use(load_use),
      .i_w_rd(w_rd), .i_w_rf_we(w_rf_we), .i_w_sets_nzp(w_sets_nzp), .i_w_data(w_data),
      .i_nzp(nzp),
      .o_flush(flush), .o_branch_target(branch_target),
      .o_x_rd(x_rd), .o_x_rf_we(x_rf_we), .o_x_is_load(x_is_load),
      .o_m_pc(m_pc), .o_m_insn(m_insn), .o_m_stall(m_stall),
      .o_m_rd(m_rd), .o_m_rt(m_rt), .o_m_rf_we(m_rf_we), .o_m_sets_nzp(m_sets_nzp),
      .o_m_is_load(m_is_load), .o_m_is_store(m_is_store),
      .o_m_result(m_result), .o_m_rt_data(m_rt_data)
   );

   lc4_memwb memwb0 (
      .gwe(gwe), .i_reset(i_reset),
      .i_m_pc(m_pc), .i_m_insn(m_insn), .i_m_stall(m_stall),
      .i_m_rd(m_rd), .i_m_rt(m_rt), .i_m_rf_we(m_rf_we), .i_m_sets_nzp(m_sets_nzp),
      .i_m_is_load(m_is_load), .i_m_is_store(m_is_store),
      .i_m_result(m_result), .i_m_rt_data(m_rt_data),
      .i_dmem_rdata(i_dmem_rdata), .o_dmem_addr(o_dmem_addr),
      .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
      .o_w_rd(w_rd), .o_w_rf_we(w_rf_we), .o_w_sets_nzp(w_sets_nzp),
      .o_w_data(w_data), .o_nzp(nzp),
      .o_test_stall(o_test_stall), .o_test_pc(o_test_pc), .o_test_insn(o_test_insn),
      .o_test_rf_we(o_test_rf_we), .o_test_rf_wsel(o_test_rf_wsel),
      .o_test_rf_data(o_test_rf_data),
      .o_test_dmem_we(o_test_dmem_we), .o_test_dmem_addr(o_test_dmem_addr),
      .o_test_dmem_data(o_test_dmem_data)
   );

endmodule

// File: rtl/lc4_decode.sv
`timescale 1ns/1ps

module lc4_decode import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  word_t    i_insn,
   input  stall_e   i_stall,
   input  reg_sel_t i_x_rd,
   input  logic     i_x_rf_we,
   input  logic     i_x_is_load,
   output reg_sel_t o_rs,
   output reg_sel_t o_rt,
   output reg_sel_t o_rd,
   output logic     o_rs_re,
   output logic     o_rt_re,
   output logic     o_rf_we,
   output logic     o_sets_nzp,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_is_branch,
   output alu_op_e  o_alu_op,
   output logic     o_load_use
);

   opcode_e opcode;

   assign opcode = opcode_e'(i_insn[15:12]);

   always_comb begin
      o_rs        = i_insn[8:6];
      o_rt        = i_insn[2:0];
      o_rd        = i_insn[11:9];
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      o_alu_op    = ALU_PASS;
      case (opcode)
         OP_BR: begin
            o_is_branch = 1'b1;
         end
         OP_ARITH: begin
            // MUL and DIV stay as NOPs
            if (i_insn[5]) begin
               o_alu_op = ALU_ADD_IMM;
            end else if (i_insn[4:3] == 2'b00) begin
               o_alu_op = ALU_ADD;
            end else if (i_insn[4:3] == 2'b10) begin
               o_alu_op = ALU_SUB;
            end
         end
         OP_LOGIC: begin
            if (i_insn[5]) begin
               o_alu_op = ALU_AND_IMM;
            end else begin
               case (i_insn[4:3])
                  2'b00:   o_alu_op = ALU_AND;
                  2'b01:   o_alu_op = ALU_NOT;
                  2'b10:   o_alu_op = ALU_OR;
                  default: o_alu_op = ALU_XOR;
               endcase
            end
         end
         OP_LDR: begin
            o_alu_op  = ALU_ADDR;
            o_is_load = 1'b1;
         end
         OP_STR: begin
            o_alu_op   = ALU_ADDR;
            o_is_store = 1'b1;
            o_rt       = i_insn[11:9];
         end
         OP_CONST: begin
            o_alu_op = ALU_CONST;
         end
         default: begin
         end
      endcase

      // anything with a real ALU op writes rd, stores excepted
      o_rf_we    = (o_alu_op != ALU_PASS) && !o_is_store;
      o_sets_nzp = o_rf_we;
      o_rs_re    = !(o_alu_op inside {ALU_PASS, ALU_CONST});
      o_rt_re    = (o_alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR}) || o_is_store;
   end

   // store data comes through the WM bypass, so its rt never stalls
   assign o_load_use = (i_stall == STALL_NONE) && i_x_is_load && i_x_rf_we &&
                       ((o_rs_re && o_rs == i_x_rd) ||
                        (o_rt_re && !o_is_store && o_rt == i_x_rd) ||
                        o_is_branch);

endmodule

// File: rtl/lc4_execute.sv
`timescale 1ns/1ps

`include "lc4_cfg.svh"

module lc4_execute import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic     gwe,
   input  logic     i_reset,
   input  word_t    i_d_pc,
   input  word_t    i_d_insn,
   input  stall_e   i_d_stall,
   input  reg_sel_t i_d_rs,
   input  reg_sel_t i_d_rt,
   input  reg_sel_t i_d_rd,
   input  logic     i_d_rs_re,
   input  logic     i_d_rt_re,
   input  logic     i_d_rf_we,
   input  logic     i_d_sets_nzp,
   input  logic     i_d_is_load,
   input  logic     i_d_is_store,
   input  logic     i_d_is_branch,
   input  alu_op_e  i_d_alu_op,
   input  word_t    i_d_rs_data,
   input  word_t    i_d_rt_data,
   input  logic     i_load_use,
   input  reg_sel_t i_w_rd,
   input  logic     i_w_rf_we,
   input  logic     i_w_sets_nzp,
   input  word_t    i_w_data,
   input  nzp_t     i_nzp,
   output logic     o_flush,
   output word_t    o_branch_target,
   output reg_sel_t o_x_rd,
   output logic     o_x_rf_we,
   output logic     o_x_is_load,
   output word_t    o_m_pc,
   output word_t    o_m_insn,
   output stall_e   o_m_stall,
   output reg_sel_t o_m_rd,
   output reg_sel_t o_m_rt,
   output logic     o_m_rf_we,
   output logic     o_m_sets_nzp,
   output logic     o_m_is_load,
   output logic     o_m_is_store,
   output word_t    o_m_result,
   output word_t    o_m_rt_data
);

   word_t    x_pc, x_insn, x_rs_data, x_rt_data;
   stall_e   x_stall;
   reg_sel_t x_rs, x_rt, x_rd;
   logic     x_rs_re, x_rt_re, x_rf_we, x_sets_nzp;
   logic     x_is_load, x_is_store, x_is_branch;
   alu_op_e  x_alu_op;
   word_t    op_a, op_b, alu_result;
   logic     m_alu_wr;
   nzp_t     cur_nzp;

   // D/X latch, control side takes the bubbles
   always_ff @(posedge gwe) begin
      if (i_reset || o_flush || i_load_use) begin
         x_stall     <= (i_reset || o_flush) ? STALL_FLUSH : STALL_LOAD_USE;
         x_insn      <= `LC4_NOP;
         x_rs_re     <= 1'b0;
         x_rt_re     <= 1'b0;
         x_rf_we     <= 1'b0;
         x_sets_nzp  <= 1'b0;
         x_is_load   <= 1'b0;
         x_is_store  <= 1'b0;
         x_is_branch <= 1'b0;
         x_alu_op    <= ALU_PASS;
      end else begin
         x_stall     <= i_d_stall;
         x_insn      <= i_d_insn;
         x_rs_re     <= i_d_rs_re;
         x_rt_re     <= i_d_rt_re;
         x_rf_we     <= i_d_rf_we;
         x_sets_nzp  <= i_d_sets_nzp;
         x_is_load   <= i_d_is_load;
         x_is_store  <= i_d_is_store;
         x_is_branch <= i_d_is_branch;
         x_alu_op    <= i_d_alu_op;
      end
   end

   always_ff @(posedge gwe) begin
      x_pc      <= i_d_pc;
      x_rs      <= i_d_rs;
      x_rt      <= i_d_rt;
      x_rd      <= i_d_rd;
      x_rs_data <= i_d_rs_data;
      x_rt_data <= i_d_rt_data;
   end

   // a load in M only has its address, the stall keeps consumers away
   assign m_alu_wr = o_m_rf_we && !o_m_is_load;

   // MX ahead of WX
   always_comb begin
      if (x_rs_re && m_alu_wr && o_m_rd == x_rs) begin
         op_a = o_m_result;
      end else if (x_rs_re && i_w_rf_we && i_w_rd == x_rs) begin
         op_a = i_w_data;
      end else begin
         op_a = x_rs_data;
      end
   end

   always_comb begin
      if (x_rt_re && m_alu_wr && o_m_rd == x_rt) begin
         op_b = o_m_result;
      end else if (x_rt_re && i_w_rf_we && i_w_rd == x_rt) begin
         op_b = i_w_data;
      end else begin
         op_b = x_rt_data;
      end
   end

   lc4_alu alu0 (
      .i_op(x_alu_op), .i_pc(x_pc), .i_insn(x_insn),
      .i_a(op_a), .i_b(op_b), .o_result(alu_result)
   );

   // codes of the youngest older producer still in flight
   always_comb begin
      if (o_m_sets_nzp && !o_m_is_load) begin
         cur_nzp = nzp_of(o_m_result);
      end else if (i_w_sets_nzp) begin
         cur_nzp = nzp_of(i_w_data);
      end else begin
         cur_nzp = i_nzp;
      end
   end

   assign o_flush         = x_is_branch && |(x_insn[11:9] & cur_nzp);
   assign o_branch_target = alu_result;
   assign o_x_rd          = x_rd;
   assign o_x_rf_we       = x_rf_we;
   assign o_x_is_load     = x_is_load;

   // X/M latch
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_m_stall    <= STALL_FLUSH;
         o_m_insn     <= `LC4_NOP;
         o_m_rf_we    <= 1'b0;
         o_m_sets_nzp <= 1'b0;
         o_m_is_load  <= 1'b0;
         o_m_is_store <= 1'b0;
      end else begin
         o_m_stall    <= x_stall;
         o_m_insn     <= x_insn;
         o_m_rf_we    <= x_rf_we;
         o_m_sets_nzp <= x_sets_nzp;
         o_m_is_load  <= x_is_load;
         o_m_is_store <= x_is_store;
      end
   end

   always_ff @(posedge gwe) begin
      o_m_pc      <= x_pc;
      o_m_rd      <= x_rd;
      o_m_rt      <= x_rt;
      o_m_result  <= alu_result;
      o_m_rt_data <= op_b;
   end

endmodule

// File: rtl/lc4_fetch.sv
`timescale 1ns/1ps

`include "lc4_cfg.svh"

module lc4_fetch import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic   gwe,
   input  logic   i_reset,
   input  logic   i_load_use,
   input  logic   i_flush,
   input  word_t  i_branch_target,
   input  word_t  i_imem_insn,
   output word_t  o_imem_addr,
   output word_t  o_d_pc,
   output word_t  o_d_insn,
   output stall_e o_d_stall
);

   word_t pc;
   word_t pc_next;

   // predict not taken, redirect when X resolves a taken branch
   always_comb begin
      if (i_flush) begin
         pc_next = i_branch_target;
      end else if (i_load_use) begin
         pc_next = pc;
      end else begin
         pc_next = pc + word_t'(1);
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc <= `LC4_PC_RESET;
      end else begin
         pc <= pc_next;
      end
   end

   assign o_imem_addr = pc;

   // F/D latch, wrong-path fetch becomes a flush bubble
   always_ff @(posedge gwe) begin
      if (i_reset || i_flush) begin
         o_d_insn  <= `LC4_NOP;
         o_d_stall <= STALL_FLUSH;
      end else if (!i_load_use) begin
         o_d_insn  <= i_imem_insn;
         o_d_stall <= STALL_NONE;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_load_use) begin
         o_d_pc <= pc;
      end
   end

endmodule

// File: rtl/lc4_isa_pkg.sv
`include "lc4_cfg.svh"

package lc4_isa_pkg;

   typedef logic [`LC4_WORD_W-1:0] word_t;
   typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;

   // negative in the msb, positive in the lsb
   typedef logic [2:0] nzp_t;

   // only the opcodes the core decodes
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_NOT,
      ALU_OR,
      ALU_XOR,
      ALU_ADD_IMM,
      ALU_AND_IMM,
      ALU_CONST,
      ALU_ADDR,
      ALU_PASS
   } alu_op_e;

   // condition code of a value written to the register file
   function automatic nzp_t nzp_of(word_t value);
      if (value == '0) begin
         return 3'b010;
      end
      return value[$bits(word_t)-1] ? 3'b100 : 3'b001;
   endfunction

endpackage

// File: rtl/lc4_memwb.sv
`timescale 1ns/1ps

`include "lc4_cfg.svh"

module lc4_memwb import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic     gwe,
   input  logic     i_reset,
   input  word_t    i_m_pc,
   input  word_t    i_m_insn,
   input  stall_e   i_m_stall,
   input  reg_sel_t i_m_rd,
   input  reg_sel_t i_m_rt,
   input  logic     i_m_rf_we,
   input  logic     i_m_sets_nzp,
   input  logic     i_m_is_load,
   input  logic     i_m_is_store,
   input  word_t    i_m_result,
   input  word_t    i_m_rt_data,
   input  word_t    i_dmem_rdata,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   output reg_sel_t o_w_rd,
   output logic     o_w_rf_we,
   output logic     o_w_sets_nzp,
   output word_t    o_w_data,
   output nzp_t     o_nzp,
   output stall_e   o_test_stall,
   output word_t    o_test_pc,
   output word_t    o_test_insn,
   output logic     o_test_rf_we,
   output reg_sel_t o_test_rf_wsel,
   output word_t    o_test_rf_data,
   output logic     o_test_dmem_we,
   output word_t    o_test_dmem_addr,
   output word_t    o_test_dmem_data
);

   logic  w_is_load;
   logic  w_is_store;
   word_t w_result;
   word_t w_rdata;
   word_t w_sdata;

   // W is always the instruction right before M, so its value is the newest
   assign o_dmem_wdata = (o_w_rf_we && o_w_rd == i_m_rt) ? o_w_data : i_m_rt_data;
   assign o_dmem_we    = i_m_is_store;
   assign o_dmem_addr  = (i_m_is_load || i_m_is_store) ? i_m_result : '0;

   // M/W latch
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_test_stall <= STALL_FLUSH;
         o_test_insn  <= `LC4_NOP;
         o_w_rf_we    <= 1'b0;
         o_w_sets_nzp <= 1'b0;
         w_is_load    <= 1'b0;
         w_is_store   <= 1'b0;
      end else begin
         o_test_stall <= i_m_stall;
         o_test_insn  <= i_m_insn;
         o_w_rf_we    <= i_m_rf_we;
         o_w_sets_nzp <= i_m_sets_nzp;
         w_is_load    <= i_m_is_load;
         w_is_store   <= i_m_is_store;
      end
   end

   always_ff @(posedge gwe) begin
      o_test_pc <= i_m_pc;
      o_w_rd    <= i_m_rd;
      w_result  <= i_m_result;
      w_rdata   <= i_dmem_rdata;
      w_sdata   <= o_dmem_wdata;
   end

   assign o_w_data = w_is_load ? w_rdata : w_result;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_nzp <= '0;
      end else if (o_w_sets_nzp) begin
         o_nzp <= nzp_of(o_w_data);
      end
   end

   // trace of the retiring slot
   assign o_test_rf_we     = o_w_rf_we;
   assign o_test_rf_wsel   = o_w_rd;
   assign o_test_rf_data   = o_w_data;
   assign o_test_dmem_we   = w_is_store;
   assign o_test_dmem_addr = (w_is_load || w_is_store) ? w_result : '0;
   assign o_test_dmem_data = w_is_store ? w_sdata : (w_is_load ? w_rdata : '0);

endmodule

// File: rtl/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

   // code carried by every pipeline slot up to the trace
   typedef enum logic [1:0] {
      STALL_NONE     = 2'd0,
      STALL_FLUSH    = 2'd2,
      STALL_LOAD_USE = 2'd3
   } stall_e;

endpackage

// File: rtl/lc4_regfile.sv
`timescale 1ns/1ps

`include "lc4_cfg.svh"

module lc4_regfile import lc4_isa_pkg::*; (
   input  logic     gwe,
   input  logic     i_reset,
   input  reg_sel_t i_rs,
   input  reg_sel_t i_rt,
   output word_t    o_rs_data,
   output word_t    o_rt_data,
   input  reg_sel_t i_rd,
   input  word_t    i_wdata,
   input  logic     i_we
);

   word_t regs [`LC4_REG_COUNT];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < `LC4_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-through covers the W to D distance
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_lc4_core -o tb_lc4_core_sim
./obj_dir/tb_lc4_core_sim | tee sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: testbench/tb_lc4_core.sv
`timescale 1ns/1ps

`include "lc4_cfg.svh"

module tb_lc4_core import lc4_isa_pkg::*, lc4_pipe_pkg::*;;

   localparam int RETIRE_TARGET  = 400;
   localparam int TIMEOUT_CYCLES = RETIRE_TARGET * 3 + 20;
   localparam int MEM_WORDS      = 256;

   logic     gwe;
   logic     reset;
   word_t    imem_addr, imem_insn;
   word_t    dmem_addr, dmem_wdata, dmem_rdata;
   logic     dmem_we;
   stall_e   test_stall;
   word_t    test_pc, test_insn, test_rf_data, test_dmem_addr, test_dmem_data;
   logic     test_rf_we, test_dmem_we;
   reg_sel_t test_rf_wsel;

   word_t imem [MEM_WORDS];
   word_t dmem [MEM_WORDS];

   // architectural state of the reference model
   word_t ref_imem [MEM_WORDS];
   word_t ref_dmem [MEM_WORDS];
   word_t ref_regs [`LC4_REG_COUNT];
   nzp_t  ref_nzp;
   word_t ref_pc;

   // what the next retiring slot should show
   word_t    exp_pc, exp_insn, exp_rf_data, exp_dmem_addr, exp_dmem_data;
   logic     exp_rf_we, exp_dmem_we, exp_mem_op;
   reg_sel_t exp_wsel;

   integer seed;
   int     flush_left;
   int     lu_left;
   int     retired;
   int     slot_count;
   int     cycle_count;

   lc4_core dut0 (
      .gwe(gwe), .i_reset(reset),
      .o_imem_addr(imem_addr), .i_imem_insn(imem_insn),
      .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_we(dmem_we),
      .i_dmem_rdata(dmem_rdata),
      .o_test_stall(test_stall), .o_test_pc(test_pc), .o_test_insn(test_insn),
      .o_test_rf_we(test_rf_we), .o_test_rf_wsel(test_rf_wsel),
      .o_test_rf_data(test_rf_data),
      .o_test_dmem_we(test_dmem_we), .o_test_dmem_addr(test_dmem_addr),
      .o_test_dmem_data(test_dmem_data)
   );

   always #5 gwe = ~gwe;

   // both memories wrap on the low address byte
   assign imem_insn  = imem[imem_addr[7:0]];
   assign dmem_rdata = dmem[dmem_addr[7:0]];

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr[7:0]] <= dmem_wdata;
      end
   end

   always @(posedge gwe) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("timeout: %0d of %0d instructions retired after %0d cycles",
                  retired, RETIRE_TARGET, cycle_count);
         $display("TEST RESULT: FAIL");
         $fatal(1, "simulation stopped by timeout");
      end
   end

   task automatic stop_on_error(string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic compare_word(string name, word_t expected, word_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   task automatic compare_sel(string name, reg_sel_t expected, reg_sel_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
      end
   endtask

   task automatic compare_stall(string name, stall_e expected, stall_e actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: expected %s, actual %s (%0d)", name,
                                 expected.name(), actual.name(), actual));
      end
   endtask

   function automatic word_t sext(word_t field, int width);
      word_t upper;
      upper = word_t'(16'hffff << width);
      return field[width-1] ? (field | upper) : (field & ~upper);
   endfunction

   function automatic nzp_t cond_of(word_t value);
      if (value[15]) begin
         return 3'b100;
      end else if (value != 16'h0000) begin
         return 3'b001;
      end
      return 3'b010;
   endfunction

   // does insn have to wait one slot behind a load of ld_rd
   function automatic logic waits_on_load(word_t insn, reg_sel_t ld_rd);
      logic rs_hit;
      logic rt_hit;
      rs_hit = (insn[8:6] == ld_rd);
      rt_hit = (insn[2:0] == ld_rd);
      case (insn[15:12])
         4'b0000: return 1'b1;
         4'b0001: return insn[5] ? rs_hit : (rs_hit || rt_hit);
         4'b0101: return (insn[5] || insn[4:3] == 2'b01) ? rs_hit : (rs_hit || rt_hit);
         // store data is forwarded late so only the base register counts
         4'b0110, 4'b0111: return rs_hit;
         default: return 1'b0;
      endcase
   endfunction

   task automatic fill_memories();
      word_t bits;
      word_t insn;
      int    kind;
      for (int i = 0; i < MEM_WORDS; i++) begin
         bits = word_t'($random(seed));
         kind = int'($unsigned($random(seed)) % 14);
         case (kind)
            0:       insn = {4'b0001, bits[11:6], 3'b000, bits[2:0]};
            1:       insn = {4'b0001, bits[11:6], 3'b010, bits[2:0]};
            2:       insn = {4'b0001, bits[11:6], 1'b1, bits[4:0]};
            // AND, NOT, OR and XOR by the two sub-opcode bits
            3:       insn = {4'b0101, bits[11:6], 1'b0, bits[4:0]};
            4:       insn = {4'b0101, bits[11:6], 1'b1, bits[4:0]};
            5, 6:    insn = {4'b1001, bits[11:0]};
            7, 8, 9: insn = {4'b0110, bits[11:0]};
            10, 11:  insn = {4'b0111, bits[11:0]};
            default: insn = {4'b0000, bits[11:0]};
         endcase
         imem[i]     = insn;
         ref_imem[i] = insn;
         bits        = word_t'($random(seed));
         dmem[i]     = bits;
         ref_dmem[i] = bits;
      end
   endtask

   // run one instruction in program order and set the expected trace
   task automatic model_step();
      word_t    insn;
      word_t    a;
      word_t    b;
      word_t    next_pc;
      reg_sel_t rd;
      logic     taken;
      insn          = ref_imem[ref_pc[7:0]];
      rd            = insn[11:9];
      a             = ref_regs[insn[8:6]];
      b             = ref_regs[insn[2:0]];
      next_pc       = ref_pc + 16'd1;
      taken         = 1'b0;
      exp_pc        = ref_pc;
      exp_insn      = insn;
      exp_wsel      = rd;
      exp_rf_we     = 1'b0;
      exp_rf_data   = '0;
      exp_dmem_we   = 1'b0;
      exp_mem_op    = 1'b0;
      exp_dmem_addr = '0;
      exp_dmem_data = '0;
      case (insn[15:12])
         4'b0001: begin
            exp_rf_we = 1'b1;
            if (insn[5]) begin
               exp_rf_data = a + sext(word_t'(insn[4:0]), 5);
            end else if (insn[4]) begin
               exp_rf_data = a - b;
            end else begin
               exp_rf_data = a + b;
            end
         end
         4'b0101: begin
            exp_rf_we = 1'b1;
            if (insn[5]) begin
               exp_rf_data = a & sext(word_t'(insn[4:0]), 5);
            end else begin
               case (insn[4:3])
                  2'b00:   exp_rf_data = a & b;
                  2'b01:   exp_rf_data = ~a;
                  2'b10:   exp_rf_data = a | b;
                  default: exp_rf_data = a ^ b;
               endcase
            end
         end
         4'b1001: begin
            exp_rf_we   = 1'b1;
            exp_rf_data = sext(word_t'(insn[8:0]), 9);
         end
         4'b0110: begin
            exp_rf_we     = 1'b1;
            exp_mem_op    = 1'b1;
            exp_dmem_addr = a + sext(word_t'(insn[5:0]), 6);
            exp_rf_data   = ref_dmem[exp_dmem_addr[7:0]];
            exp_dmem_data = exp_rf_data;
         end
         4'b0111: begin
            exp_dmem_we   = 1'b1;
            exp_mem_op    = 1'b1;
            exp_dmem_addr = a + sext(word_t'(insn[5:0]), 6);
            exp_dmem_data = ref_regs[rd];
            ref_dmem[exp_dmem_addr[7:0]] = exp_dmem_data;
         end
         default: begin
            // BR with an empty mask never matches
            if ((insn[11:9] & ref_nzp) != 3'b000) begin
               taken   = 1'b1;
               next_pc = ref_pc + 16'd1 + sext(word_t'(insn[8:0]), 9);
            end
         end
      endcase
      if (exp_rf_we) begin
         ref_regs[rd] = exp_rf_data;
         ref_nzp      = cond_of(exp_rf_data);
      end
      ref_pc = next_pc;
      // bubbles owed ahead of the next instruction
      if (taken) begin
         flush_left = 2;
      end else if (insn[15:12] == 4'b0110 && waits_on_load(ref_imem[ref_pc[7:0]], rd)) begin
         lu_left = 1;
      end
   endtask

   task automatic score_slot();
      stall_e exp_stall;
      string  tag;
      if (flush_left > 0) begin
         exp_stall = STALL_FLUSH;
      end else if (lu_left > 0) begin
         exp_stall = STALL_LOAD_USE;
      end else begin
         exp_stall = STALL_NONE;
      end
      tag = $sformatf("slot %0d", slot_count);
      slot_count++;
      compare_stall({tag, " stall"}, exp_stall, test_stall);
      if (exp_stall != STALL_NONE) begin
         compare_word({tag, " bubble rf_we"}, '0, word_t'(test_rf_we));
         compare_word({tag, " bubble dmem_we"}, '0, word_t'(test_dmem_we));
         if (exp_stall == STALL_FLUSH) begin
            flush_left--;
         end else begin
            lu_left--;
         end
      end else begin
         model_step();
         tag = $sformatf("insn %0d", retired);
         compare_word({tag, " pc"}, exp_pc, test_pc);
         compare_word({tag, " insn"}, exp_insn, test_insn);
         compare_word({tag, " rf_we"}, word_t'(exp_rf_we), word_t'(test_rf_we));
         if (exp_rf_we) begin
            compare_sel({tag, " rf_wsel"}, exp_wsel, test_rf_wsel);
            compare_word({tag, " rf_data"}, exp_rf_data, test_rf_data);
         end
         compare_word({tag, " dmem_we"}, word_t'(exp_dmem_we), word_t'(test_dmem_we));
         if (exp_mem_op) begin
            compare_word({tag, " dmem_addr"}, exp_dmem_addr, test_dmem_addr);
            compare_word({tag, " dmem_data"}, exp_dmem_data, test_dmem_data);
         end
         retired++;
      end
   endtask

   task automatic verify_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         compare_word($sformatf("dmem[%0d] at end", i), ref_dmem[i], dmem[i]);
      end
   endtask

   initial begin
      seed        = 32'h1ae7;
      gwe         = 1'b0;
      reset       = 1'b1;
      cycle_count = 0;
      retired     = 0;
      slot_count  = 0;
      lu_left     = 0;
      // F/D, D/X and X/M come out of reset holding flush bubbles
      flush_left  = 3;
      ref_nzp     = 3'b000;
      ref_pc      = `LC4_PC_RESET;
      for (int i = 0; i < `LC4_REG_COUNT; i++) begin
         ref_regs[i] = '0;
      end
      fill_memories();
      repeat (3) @(posedge gwe);
      #1;
      reset = 1'b0;
      // W keeps its own reset slot until the first edge after release
      @(posedge gwe);
      while (retired < RETIRE_TARGET) begin
         @(negedge gwe);
         score_slot();
      end
      verify_memory();
      $display("%0d instructions retired in %0d slots", retired, slot_count);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+include
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_alu.sv
rtl/lc4_fetch.sv
rtl/lc4_decode.sv
rtl/lc4_regfile.sv
rtl/lc4_execute.sv
rtl/lc4_memwb.sv
rtl/lc4_core.sv
testbench/tb_lc4_core.sv
